// ==== Bender.yml ====
package:
  name: memory_upload

sources:
  - files:
      - hdl/upload_pkg.sv
      - hdl/ddr_byte_reader.sv
      - hdl/record_parser.sv
      - hdl/region_filler.sv
      - hdl/slot_layout_writer.sv
      - hdl/memory_upload.sv
  - target: test
    files:
      - tests/memory_upload_tb.sv

// ==== build.f ====
hdl/upload_pkg.sv
hdl/ddr_byte_reader.sv
hdl/record_parser.sv
hdl/region_filler.sv
hdl/slot_layout_writer.sv
hdl/memory_upload.sv
tests/memory_upload_tb.sv

// ==== hdl/ddr_byte_reader.sv ====
`timescale 1ns/100ps

module ddr_byte_reader (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   input  upload_pkg::ddr_addr_t  image_size,
   output logic                   ddr_rd,
   output upload_pkg::ddr_addr_t  ddr_addr,
   input  logic                   ddr_ready,
   input  upload_pkg::byte_t      ddr_dout,
   output logic                   beat_valid,
   output upload_pkg::byte_beat_t beat,
   input  logic                   beat_ready
);
   logic running;
   logic capture;   // Read data on ddr_dout this cycle
   logic issue;

   // One read in flight, and only when the buffer is free by the time data lands
   assign issue = running && !ddr_rd && !capture && (!beat_valid || beat_ready) &&
                  ddr_addr < image_size;

   always_ff @(posedge clk) begin
      if (rst || start) begin
         running    <= !rst;
         ddr_rd     <= 1'b0;
         ddr_addr   <= '0;
         capture    <= 1'b0;
         beat_valid <= 1'b0;
      end else begin
         capture <= ddr_rd && ddr_ready;
         if (ddr_rd && ddr_ready) begin
            ddr_rd   <= 1'b0;
            ddr_addr <= ddr_addr + 1'b1;
         end else if (issue) begin
            ddr_rd <= 1'b1;
         end
         if (capture) beat_valid <= 1'b1;
         else if (beat_ready) beat_valid <= 1'b0;
      end
   end

   // Address already stepped past the fetched byte
   always_ff @(posedge clk) begin
      if (capture) beat <= '{data: ddr_dout, last: ddr_addr == image_size};
   end

endmodule

// ==== hdl/memory_upload.sv ====
`timescale 1ns/100ps

module memory_upload #(
   parameter int PAGE_BITS  = 14,
   parameter int RAM_ADDR_W = 27
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  upload_pkg::ddr_addr_t     image_size,
   output logic                      ddr_rd,
   output upload_pkg::ddr_addr_t     ddr_addr,
   input  logic                      ddr_ready,
   input  upload_pkg::byte_t         ddr_dout,
   output logic                      ram_we,
   output upload_pkg::ram_addr_t     ram_addr,
   output upload_pkg::byte_t         ram_din,
   input  logic                      ram_ready,
   input  logic [5:0]                layout_index,
   output upload_pkg::layout_entry_t layout_entry,
   input  upload_pkg::ref_index_t    ref_index,
   output upload_pkg::ram_ref_t      ref_entry,
   output logic                      done,
   output logic                      bad_image
);
   logic                    beat_valid;
   logic                    beat_ready;
   upload_pkg::byte_beat_t  beat;
   logic                    req_valid;
   logic                    req_ready;
   upload_pkg::region_req_t req;
   logic                    pay_valid;
   logic                    pay_ready;
   upload_pkg::byte_t       pay;
   logic                    lay_valid;
   logic                    lay_ready;
   upload_pkg::layout_req_t lay;

   ddr_byte_reader ddr_byte_reader_inst (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .image_size (image_size),
      .ddr_rd     (ddr_rd),
      .ddr_addr   (ddr_addr),
      .ddr_ready  (ddr_ready),
      .ddr_dout   (ddr_dout),
      .beat_valid (beat_valid),
      .beat       (beat),
      .beat_ready (beat_ready)
   );

   record_parser #(.PAGE_BITS(PAGE_BITS)) record_parser_inst (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .image_size (image_size),   // Empty image check
      .beat_valid (beat_valid),
      .beat       (beat),
      .beat_ready (beat_ready),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .pay_valid  (pay_valid),
      .pay        (pay),
      .pay_ready  (pay_ready)
   );

   region_filler #(.PAGE_BITS(PAGE_BITS), .RAM_ADDR_W(RAM_ADDR_W)) region_filler_inst (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .pay_valid (pay_valid),
      .pay       (pay),
      .pay_ready (pay_ready),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_din   (ram_din),
      .ram_ready (ram_ready),
      .lay_valid (lay_valid),
      .lay       (lay),
      .lay_ready (lay_ready),
      .ref_index (ref_index),
      .ref_entry (ref_entry)
   );

   slot_layout_writer slot_layout_writer_inst (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .lay_valid    (lay_valid),
      .lay          (lay),
      .lay_ready    (lay_ready),
      .layout_index (layout_index),
      .layout_entry (layout_entry),
      .done         (done),
      .bad_image    (bad_image)
   );

endmodule

// ==== hdl/record_parser.sv ====
`timescale 1ns/100ps

module record_parser #(
   parameter int PAGE_BITS = 14
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  upload_pkg::ddr_addr_t   image_size,
   input  logic                    beat_valid,
   input  upload_pkg::byte_beat_t  beat,
   output logic                    beat_ready,
   output logic                    req_valid,
   output upload_pkg::region_req_t req,
   input  logic                    req_ready,
   output logic                    pay_valid,
   output upload_pkg::byte_t       pay,
   input  logic                    pay_ready
);
   upload_pkg::parser_state_t state;
   upload_pkg::byte_t         hdr [12];   // Bytes past 11 carry nothing we use
   logic [3:0]                cnt;
   logic                      at_end;     // Final image byte already taken
   logic [PAGE_BITS+10:0]     pay_left;
   logic                      beat_fire;
   logic                      magic_ok;

   assign beat_ready = (state == upload_pkg::P_HEADER && !at_end) ||
                       (state == upload_pkg::P_PAYLOAD && pay_ready);
   assign beat_fire  = beat_valid && beat_ready;
   assign pay_valid  = state == upload_pkg::P_PAYLOAD && beat_valid;
   assign pay        = beat.data;
   assign req_valid  = state == upload_pkg::P_REQ;
   assign magic_ok   = {hdr[0], hdr[1], hdr[2]} == "MSX";

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= upload_pkg::P_DONE;
         cnt    <= '0;
         at_end <= 1'b0;
      end else if (start) begin
         state  <= upload_pkg::P_HEADER;
         cnt    <= '0;
         at_end <= image_size == '0;
      end else begin
         if (beat_fire && beat.last) at_end <= 1'b1;
         case (state)
            upload_pkg::P_HEADER: begin
               if (at_end) begin
                  state <= upload_pkg::P_REQ;   // Stop request
               end else if (beat_fire) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == 4'(upload_pkg::RECORD_BYTES - 1) &&
                      (!magic_ok || hdr[3][7:4] == upload_pkg::RECORD_SLOT))
                     state <= upload_pkg::P_REQ;
               end
            end
            upload_pkg::P_REQ: begin
               if (req_ready) begin
                  if (req.stop) state <= upload_pkg::P_DONE;
                  else if (req.data_id == upload_pkg::DATA_ROM && req.pages != '0)
                     state <= upload_pkg::P_PAYLOAD;
                  else state <= upload_pkg::P_HEADER;
               end
            end
            upload_pkg::P_PAYLOAD: begin
               if (beat_fire && pay_left == 1) state <= upload_pkg::P_HEADER;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == upload_pkg::P_HEADER) begin
         if (at_end) begin
            req.stop <= 1'b1;
            req.bad  <= 1'b0;
         end else if (beat_fire) begin
            if (cnt < 4'd12) hdr[cnt] <= beat.data;
            if (cnt == 4'(upload_pkg::RECORD_BYTES - 1))
               req <= '{slot_sub: hdr[3][3:0], data_id: hdr[4],
                        pages: {hdr[5][2:0], hdr[6]}, device: hdr[7], mapper: hdr[8],
                        mode: hdr[9], param: hdr[10], pattern: hdr[11][2:0],
                        stop: !magic_ok, bad: !magic_ok};
         end
      end
      if (state == upload_pkg::P_REQ) pay_left <= {req.pages, {PAGE_BITS{1'b0}}};
      else if (state == upload_pkg::P_PAYLOAD && beat_fire) pay_left <= pay_left - 1'b1;
   end

endmodule

// ==== hdl/region_filler.sv ====
`timescale 1ns/100ps

module region_filler #(
   parameter int PAGE_BITS  = 14,
   parameter int RAM_ADDR_W = 27
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  logic                    req_valid,
   input  upload_pkg::region_req_t req,
   output logic                    req_ready,
   input  logic                    pay_valid,
   input  upload_pkg::byte_t       pay,
   output logic                    pay_ready,
   output logic                    ram_we,
   output upload_pkg::ram_addr_t   ram_addr,
   output upload_pkg::byte_t       ram_din,
   input  logic                    ram_ready,
   output logic                    lay_valid,
   output upload_pkg::layout_req_t lay,
   input  logic                    lay_ready,
   input  upload_pkg::ref_index_t  ref_index,
   output upload_pkg::ram_ref_t    ref_entry
);
   upload_pkg::filler_state_t state;
   upload_pkg::ram_ref_t      ref_tab [16];
   logic [RAM_ADDR_W-1:0]     next_addr;    // Write pointer, regions packed back to back
   upload_pkg::ref_index_t    ref_cnt;
   logic [PAGE_BITS+10:0]     pos;          // Offset within region
   logic [PAGE_BITS+10:0]     last_pos;
   logic                      use_pay;
   upload_pkg::fill_pattern_t pattern;
   upload_pkg::byte_t         fill_byte;
   logic                      take;
   logic                      alloc;

   assign take      = req_valid && req_ready;
   assign alloc     = !req.stop && req.pages != '0;
   assign req_ready = state == upload_pkg::F_IDLE;
   assign lay_valid = state == upload_pkg::F_LAY;
   assign ram_we    = state == upload_pkg::F_FILL && (!use_pay || pay_valid);
   assign pay_ready = state == upload_pkg::F_FILL && use_pay && ram_ready;
   assign ram_addr  = upload_pkg::ram_addr_t'(next_addr);
   assign ram_din   = use_pay ? pay : fill_byte;
   assign ref_entry = ref_tab[ref_index];

   always_comb begin
      case (pattern)
         3'd2:    fill_byte = 8'h00;
         3'd3:    fill_byte = (pos[8] == pos[1]) ? 8'hFF : 8'h00;
         3'd4:    fill_byte = (pos[8] != pos[0]) ? 8'hFF : 8'h00;
         default: fill_byte = 8'hFF;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst || start) begin
         state     <= upload_pkg::F_IDLE;
         next_addr <= '0;
         ref_cnt   <= '0;
      end else begin
         case (state)
            upload_pkg::F_IDLE: begin
               if (take) begin
                  if (alloc) begin
                     ref_cnt <= ref_cnt + 1'b1;
                     state   <= upload_pkg::F_FILL;
                  end else begin
                     state <= upload_pkg::F_LAY;
                  end
               end
            end
            upload_pkg::F_FILL: begin
               if (ram_we && ram_ready) begin
                  next_addr <= next_addr + 1'b1;
                  if (pos == last_pos) state <= upload_pkg::F_LAY;
               end
            end
            upload_pkg::F_LAY: if (lay_ready) state <= upload_pkg::F_IDLE;
            default: state <= upload_pkg::F_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         lay <= '{slot_sub: req.slot_sub, data_id: req.data_id, ref_idx: ref_cnt,
                  device: req.device, mapper: req.mapper, mode: req.mode,
                  param: req.param, stop: req.stop, bad: req.bad};
         use_pay  <= req.data_id == upload_pkg::DATA_ROM;
         pattern  <= req.pattern;
         pos      <= '0;
         last_pos <= {req.pages, {PAGE_BITS{1'b0}}} - 1'b1;
         if (alloc)
            ref_tab[ref_cnt] <= '{addr: upload_pkg::ram_addr_t'(next_addr), pages: req.pages,
                                  ro: req.data_id != upload_pkg::DATA_RAM};
      end else if (ram_we && ram_ready) begin
         pos <= pos + 1'b1;
      end
   end

endmodule

// ==== hdl/slot_layout_writer.sv ====
`timescale 1ns/100ps

module slot_layout_writer (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  logic                      lay_valid,
   input  upload_pkg::layout_req_t   lay,
   output logic                      lay_ready,
   input  logic [5:0]                layout_index,
   output upload_pkg::layout_entry_t layout_entry,
   output logic                      done,
   output logic                      bad_image
);
   upload_pkg::writer_state_t state;
   upload_pkg::layout_entry_t tab [64];
   upload_pkg::layout_entry_t blk [4];   // Four blocks of lay.slot_sub after update
   logic [5:0]                clr_idx;
   upload_pkg::ref_index_t    ref_v;

   assign lay_ready    = state == upload_pkg::W_RUN;
   assign layout_entry = tab[layout_index];
   assign ref_v        = lay.data_id == upload_pkg::DATA_NONE ? '0 : lay.ref_idx;

   // Blocks in order, so a mirror sees blocks already updated
   always_comb begin
      for (int b = 0; b < 4; b++) blk[b] = tab[{lay.slot_sub, 2'(b)}];
      for (int b = 0; b < 4; b++) begin
         case (lay.mode[2*b +: 2])
            2'd1: blk[b] = blk[lay.param[2*b +: 2]];
            2'd2: blk[b] = '{mapper: lay.mapper, device: lay.device, ref_idx: ref_v,
                             offset: lay.param[2*b +: 2]};
            2'd3: blk[b] = '{mapper: upload_pkg::MAPPER_UNUSED, device: lay.device,
                             ref_idx: ref_v, offset: lay.param[2*b +: 2]};
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst || start) begin
         state     <= upload_pkg::W_CLEAR;
         clr_idx   <= '0;
         done      <= 1'b0;
         bad_image <= 1'b0;
      end else begin
         case (state)
            upload_pkg::W_CLEAR: begin
               clr_idx <= clr_idx + 1'b1;
               if (clr_idx == 6'd63) state <= upload_pkg::W_RUN;
            end
            upload_pkg::W_RUN: begin
               if (lay_valid && lay.stop) begin
                  state     <= upload_pkg::W_DONE;
                  done      <= 1'b1;
                  bad_image <= lay.bad;
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == upload_pkg::W_CLEAR) begin
         tab[clr_idx] <= '{mapper: upload_pkg::MAPPER_UNUSED,
                           device: upload_pkg::DEVICE_NONE, ref_idx: '0, offset: '0};
      end else if (state == upload_pkg::W_RUN && lay_valid && !lay.stop) begin
         for (int b = 0; b < 4; b++) tab[{lay.slot_sub, 2'(b)}] <= blk[b];
      end
   end

endmodule

// ==== hdl/upload_pkg.sv ====
package upload_pkg;

   typedef logic [27:0] ddr_addr_t;
   typedef logic [26:0] ram_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  slot_sub_t;      // Slot in [3:2], subslot in [1:0]
   typedef logic [10:0] page_count_t;
   typedef logic [3:0]  ref_index_t;
   typedef logic [7:0]  mapper_code_t;
   typedef logic [7:0]  device_code_t;
   typedef logic [7:0]  block_mode_t;    // Two bits per 16 KB block
   typedef logic [7:0]  block_param_t;
   typedef logic [2:0]  fill_pattern_t;
   typedef logic [7:0]  data_id_t;

   localparam data_id_t     DATA_NONE     = 8'd0;
   localparam data_id_t     DATA_ROM      = 8'd1;
   localparam data_id_t     DATA_RAM      = 8'd2;
   localparam logic [3:0]   RECORD_SLOT   = 4'd3;
   localparam mapper_code_t MAPPER_UNUSED = 8'd0;
   localparam device_code_t DEVICE_NONE   = 8'd0;
   localparam int           RECORD_BYTES  = 16;

   typedef struct packed {
      byte_t data;
      logic  last;
   } byte_beat_t;

   typedef struct packed {
      slot_sub_t     slot_sub;
      data_id_t      data_id;
      page_count_t   pages;
      device_code_t  device;
      mapper_code_t  mapper;
      block_mode_t   mode;
      block_param_t  param;
      fill_pattern_t pattern;
      logic          stop;
      logic          bad;
   } region_req_t;

   // ref is a keyword, hence ref_idx
   typedef struct packed {
      slot_sub_t    slot_sub;
      data_id_t     data_id;
      ref_index_t   ref_idx;
      device_code_t device;
      mapper_code_t mapper;
      block_mode_t  mode;
      block_param_t param;
      logic         stop;
      logic         bad;
   } layout_req_t;

   typedef struct packed {
      mapper_code_t mapper;
      device_code_t device;
      ref_index_t   ref_idx;
      logic [1:0]   offset;
   } layout_entry_t;

   typedef struct packed {
      ram_addr_t   addr;
      page_count_t pages;
      logic        ro;
   } ram_ref_t;

   typedef enum logic [1:0] {P_HEADER, P_REQ, P_PAYLOAD, P_DONE} parser_state_t;
   typedef enum logic [1:0] {F_IDLE, F_FILL, F_LAY} filler_state_t;
   typedef enum logic [1:0] {W_CLEAR, W_RUN, W_DONE} writer_state_t;

endpackage

// ==== tests/memory_upload_tb.sv ====
`timescale 1ns/100ps

module memory_upload_tb;
   localparam int PAGE_BITS      = 4;
   localparam int IMAGE_BYTES    = 256;   // All test images together
   localparam int TIMEOUT_CYCLES = IMAGE_BYTES * 8 + 2000;

   logic                      clk          = 1'b0;
   logic                      rst          = 1'b1;
   logic                      start        = 1'b0;
   upload_pkg::ddr_addr_t     image_size   = '0;
   logic                      ddr_rd;
   upload_pkg::ddr_addr_t     ddr_addr;
   logic                      ddr_ready    = 1'b1;
   upload_pkg::byte_t         ddr_dout     = '0;
   logic                      ram_we;
   upload_pkg::ram_addr_t     ram_addr;
   upload_pkg::byte_t         ram_din;
   logic                      ram_ready    = 1'b1;
   logic [5:0]                layout_index = '0;
   upload_pkg::layout_entry_t layout_entry;
   upload_pkg::ref_index_t    ref_index    = '0;
   upload_pkg::ram_ref_t      ref_entry;
   logic                      done;
   logic                      bad_image;

   upload_pkg::byte_t         ddr_mem [1024];
   upload_pkg::byte_t         ram_mem [4096];
   upload_pkg::byte_t         exp_ram [4096];
   upload_pkg::layout_entry_t exp_lay [64];
   upload_pkg::ram_ref_t      exp_ref [16];
   int                        img_len;
   int                        exp_writes;
   int                        exp_refs;
   logic                      exp_bad;
   logic                      model_stopped;   // Broken magic already in the image
   int                        ram_writes   = 0;
   int                        cycles       = 0;
   logic                      ddr_pending  = 1'b0;
   upload_pkg::ddr_addr_t     pending_addr;
   logic                      stall_en     = 1'b0;
   logic [31:0]               rng          = 32'd75218;

   memory_upload #(.PAGE_BITS(PAGE_BITS)) memory_upload_inst (.*);

   always #10 clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "Run stopped at cycle %0d", cycles);
   endtask

   task automatic check_entry(input string name, input upload_pkg::layout_entry_t got,
                              input upload_pkg::layout_entry_t exp);
      if (got !== exp) stop_run($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
   endtask

   task automatic check_ref(input string name, input upload_pkg::ram_ref_t got,
                            input upload_pkg::ram_ref_t exp);
      if (got !== exp) stop_run($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
   endtask

   task automatic check_byte(input string name, input upload_pkg::byte_t got,
                             input upload_pkg::byte_t exp);
      if (got !== exp) stop_run($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) stop_run($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic upload_pkg::byte_t payload_byte(input int a);
      return upload_pkg::byte_t'((a * 37) ^ (a >> 3) ^ 8'h5B);
   endfunction

   function automatic upload_pkg::byte_t pattern_byte(input upload_pkg::fill_pattern_t pat,
                                                       input int pos);
      case (pat)
         3'd1:    return 8'hFF;
         3'd2:    return 8'h00;
         3'd3:    return (pos[8] == pos[1]) ? 8'hFF : 8'h00;
         3'd4:    return (pos[8] != pos[0]) ? 8'hFF : 8'h00;
         default: return 8'hFF;
      endcase
   endfunction

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles == TIMEOUT_CYCLES) stop_run("Timeout: the load did not finish in time");
   end

   // Ports sampled mid-cycle, ahead of the edge that accepts them
   always @(negedge clk) begin
      if (ddr_rd && ddr_ready) begin
         if (ddr_addr >= 1024) stop_run("DDR read outside the image buffer");
         else begin
            ddr_pending  = 1'b1;
            pending_addr = ddr_addr;
         end
      end
      if (ram_we && ram_ready) begin
         if (ram_writes >= 4096) stop_run("RAM model overflow, too many writes");
         else if (ram_addr !== upload_pkg::ram_addr_t'(ram_writes))
            stop_run($sformatf("FAIL ram_addr: expected %h, got %h",
                               upload_pkg::ram_addr_t'(ram_writes), ram_addr));
         else begin
            ram_mem[ram_writes] = ram_din;
            ram_writes++;
         end
      end
   end

   always @(posedge clk) begin
      #2;
      if (ddr_pending) ddr_dout = ddr_mem[pending_addr[9:0]];
      ddr_pending = 1'b0;
      rng       = xorshift(rng);
      ddr_ready = !stall_en || rng[3];
      ram_ready = !stall_en || rng[17];
   end

   task automatic new_image();
      img_len       = 0;
      exp_writes    = 0;
      exp_refs      = 0;
      exp_bad       = 1'b0;
      model_stopped = 1'b0;
      for (int i = 0; i < 64; i++)
         exp_lay[i] = '{mapper: upload_pkg::MAPPER_UNUSED, device: upload_pkg::DEVICE_NONE,
                        ref_idx: '0, offset: '0};
   endtask

   // Appends one record to the image and updates the expected results
   task automatic add_record(input logic [23:0] magic, input logic [3:0] kind,
                             input upload_pkg::slot_sub_t ss, input upload_pkg::data_id_t id,
                             input upload_pkg::page_count_t pages,
                             input upload_pkg::device_code_t dev,
                             input upload_pkg::mapper_code_t map,
                             input upload_pkg::block_mode_t mode,
                             input upload_pkg::block_param_t param,
                             input upload_pkg::fill_pattern_t pat);
      upload_pkg::byte_t         hdr [16];
      upload_pkg::layout_entry_t blk [4];
      upload_pkg::ref_index_t    r;
      int                        base;
      logic                      keep;
      hdr = '{magic[23:16], magic[15:8], magic[7:0], {kind, ss}, id, {5'b0, pages[10:8]},
              pages[7:0], dev, map, mode, param, {5'b0, pat}, 8'hC0, 8'hC1, 8'hC2, 8'hC3};
      keep = !model_stopped && magic == "MSX" && kind == upload_pkg::RECORD_SLOT;
      if (!model_stopped && magic != "MSX") begin
         model_stopped = 1'b1;
         exp_bad       = 1'b1;
      end
      for (int i = 0; i < 16; i++) ddr_mem[img_len + i] = hdr[i];
      img_len += 16;
      base = img_len;
      if (id == upload_pkg::DATA_ROM) begin
         for (int i = 0; i < pages * (1 << PAGE_BITS); i++) begin
            ddr_mem[img_len] = payload_byte(base + i);
            img_len++;
         end
      end
      if (keep) begin
         r = '0;
         if (pages != '0) begin
            r = upload_pkg::ref_index_t'(exp_refs);
            exp_ref[exp_refs] = '{addr: upload_pkg::ram_addr_t'(exp_writes), pages: pages,
                                  ro: id == upload_pkg::DATA_ROM};
            exp_refs++;
            for (int i = 0; i < pages * (1 << PAGE_BITS); i++) begin
               exp_ram[exp_writes] = (id == upload_pkg::DATA_ROM) ? payload_byte(base + i)
                                                                 : pattern_byte(pat, i);
               exp_writes++;
            end
         end
         if (id == upload_pkg::DATA_NONE) r = '0;
         for (int b = 0; b < 4; b++) blk[b] = exp_lay[ss * 4 + b];
         for (int b = 0; b < 4; b++) begin
            case (mode[2*b +: 2])
               2'd1: blk[b] = blk[param[2*b +: 2]];   // Mirror of an earlier result
               2'd2: blk[b] = '{mapper: map, device: dev, ref_idx: r,
                                offset: param[2*b +: 2]};
               2'd3: blk[b] = '{mapper: upload_pkg::MAPPER_UNUSED, device: dev, ref_idx: r,
                                offset: param[2*b +: 2]};
               default: ;
            endcase
         end
         for (int b = 0; b < 4; b++) exp_lay[ss * 4 + b] = blk[b];
      end
   endtask

   task automatic run_load();
      @(posedge clk);
      #2;
      ram_writes = 0;
      image_size = upload_pkg::ddr_addr_t'(img_len);
      start      = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
      @(negedge clk);
      while (done !== 1'b1) @(negedge clk);
   endtask

   task automatic check_results();
      check_flag("bad_image", bad_image, exp_bad);
      if (ram_writes != exp_writes)
         stop_run($sformatf("FAIL ram write count: expected %h, got %h",
                            exp_writes, ram_writes));
      for (int i = 0; i < exp_writes; i++)
         check_byte($sformatf("ram[%0d]", i), ram_mem[i], exp_ram[i]);
      for (int i = 0; i < 64; i++) begin
         @(posedge clk);
         #2;
         layout_index = 6'(i);
         ref_index    = 4'(i);
         @(negedge clk);
         check_entry($sformatf("layout_entry[%0d]", i), layout_entry, exp_lay[i]);
         if (i < exp_refs) check_ref($sformatf("ref_entry[%0d]", i), ref_entry, exp_ref[i]);
      end
      check_flag("done", done, 1'b1);   // Held until the next start
      check_flag("bad_image", bad_image, exp_bad);
   endtask

   task automatic test_empty();
      new_image();
      run_load();
      check_results();
   endtask

   task automatic test_rom_copy();
      new_image();
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'h6, upload_pkg::DATA_ROM, 11'd2,
                 8'h21, 8'h05, 8'hAA, 8'hE4, 3'd0);
      run_load();
      check_results();
   endtask

   task automatic test_ram_patterns();
      new_image();
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'h0, upload_pkg::DATA_RAM, 11'd1,
                 8'h10, 8'h01, 8'hAA, 8'h1B, 3'd1);
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'h1, upload_pkg::DATA_RAM, 11'd1,
                 8'h11, 8'h02, 8'hFF, 8'h1B, 3'd2);
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'h2, upload_pkg::DATA_RAM, 11'd17,
                 8'h12, 8'h03, 8'h0A, 8'h04, 3'd3);   // Past 256 bytes for bit 8
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'hF, upload_pkg::DATA_RAM, 11'd17,
                 8'h13, 8'h04, 8'hA8, 8'hE4, 3'd4);
      run_load();
      check_results();
   endtask

   task automatic test_block_modes();
      new_image();
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'hD, upload_pkg::DATA_RAM, 11'd1,
                 8'h40, 8'h07, 8'hA0, 8'h50, 3'd2);
      // Modes 0,1,2,3 with block 1 mirroring block 3
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'hD, upload_pkg::DATA_NONE, 11'd0,
                 8'h41, 8'h08, 8'hE4, 8'h2C, 3'd0);
      run_load();
      check_results();
   endtask

   task automatic test_bad_magic();
      new_image();
      add_record("MSX", 4'h5, 4'h3, upload_pkg::DATA_RAM, 11'd1,
                 8'h50, 8'h09, 8'hAA, 8'h00, 3'd1);
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'h3, upload_pkg::DATA_RAM, 11'd1,
                 8'h51, 8'h0A, 8'hAA, 8'hE4, 3'd4);
      add_record("MSY", upload_pkg::RECORD_SLOT, 4'h4, upload_pkg::DATA_RAM, 11'd1,
                 8'h52, 8'h0B, 8'hAA, 8'hE4, 3'd1);
      add_record("MSX", upload_pkg::RECORD_SLOT, 4'h5, upload_pkg::DATA_RAM, 11'd2,
                 8'h53, 8'h0C, 8'hAA, 8'hE4, 3'd2);
      run_load();
      repeat (120) @(posedge clk);   // Room for stray writes from the trailing record
      check_results();
   endtask

   task automatic test_back_pressure();
      stall_en = 1'b1;
      test_rom_copy();
      stall_en = 1'b0;
   endtask

   initial begin
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      check_flag("ddr_rd", ddr_rd, 1'b0);
      check_flag("ram_we", ram_we, 1'b0);
      check_flag("done", done, 1'b0);
      check_flag("bad_image", bad_image, 1'b0);
      test_empty();
      test_rom_copy();
      test_ram_patterns();
      test_block_modes();
      test_bad_magic();
      test_back_pressure();
      $display("Simulation passed");
      $finish;
   end

endmodule
